// File: Makefile
# Verilator build, run and lint of the peripheral subsystem testbench

TOP := periph_tb

.PHONY: run lint clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "^=== PASS ===$$" sim.log

obj_dir/V$(TOP): vlog.f verilog/*.sv sim/*.sv
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: sim/periph_sva.sv
// Bus and host port protocol assertions
// Ack pulse width, ack only after stb, host bus enable inside wait
// Bound to the interconnect and to the host parallel port
`timescale 1ns/100ps

module periph_sva (
   input logic CLK_I,
   input logic rst_n,
   input logic stb,
   input logic ack,
   input logic db_oe,
   input logic db_wait
);
   int fails = 0;   // Failed assertions in this instance

   // Single-cycle ack
   ack_pulse: assert property (@(posedge CLK_I) disable iff (!rst_n) ack |=> !ack)
      else begin
         fails++;
         $error("ack stayed high for more than one cycle");
      end

   // Ack always answers a strobe seen one cycle earlier
   ack_after_stb: assert property (@(posedge CLK_I) disable iff (!rst_n) ack |-> $past(stb))
      else begin
         fails++;
         $error("ack without a preceding stb");
      end

   // Host data bus driven only inside the wait phase
   oe_in_wait: assert property (@(posedge CLK_I) disable iff (!rst_n) db_oe |-> db_wait)
      else begin
         fails++;
         $error("epp_db_oe high while epp_wait low");
      end

endmodule

bind periph_interconnect periph_sva u_sva (
   .CLK_I   (CLK_I),
   .rst_n   (rst_n),
   .stb     (stb),
   .ack     (ack),
   .db_oe   (1'b0),   // No host side here
   .db_wait (1'b0)
);

bind epp_port periph_sva u_sva (
   .CLK_I   (CLK_I),
   .rst_n   (rst_n),
   .stb     (stb),
   .ack     (ack),
   .db_oe   (epp_db_oe),
   .db_wait (epp_wait)
);

// File: sim/periph_tb.sv
// Testbench for the peripheral subsystem
// Bus master and host port driver tasks with a reference model
// Random LED, mailbox, unmapped and FM traffic, antenna tracking
// Cycle limit and closing verdict
`timescale 1ns/100ps

module periph_tb;
   localparam int N_BUS    = 300;   // Random bus operations
   localparam int N_HOST   = 150;   // Random host operations
   localparam int N_DIRECT = 20;    // Directed accesses, rounded up
   localparam int N_FM     = 3;     // Antenna tracking runs
   localparam int FM_CYC   = 200;
   localparam int LIMIT    = 40 * (N_BUS + N_HOST + N_DIRECT) + N_FM * (FM_CYC + 80);
   localparam logic [7:0] A_LED  = 8'(1 << soc_bus_pkg::SEL_LED_BIT);
   localparam logic [7:0] A_EPP  = 8'(1 << soc_bus_pkg::SEL_EPP_BIT);   // Mailbox byte
   localparam logic [7:0] A_STAT = A_EPP | 8'(1 << soc_bus_pkg::REG_SEL_BIT);
   localparam logic [7:0] A_FM   = 8'(1 << soc_bus_pkg::SEL_FM_BIT);

   logic        CLK_I;
   logic        rst_n;
   logic        stb;
   logic        we;
   logic [7:0]  adr;
   logic [31:0] dat_w;
   logic [31:0] dat_r;
   logic        ack;
   logic        epp_astb_n;
   logic        epp_dstb_n;
   logic        epp_write_n;
   logic [7:0]  epp_db_in;
   logic [7:0]  epp_db_out;
   logic        epp_db_oe;
   logic        epp_wait;
   logic [3:0]  led;
   logic        antenna;

   // Reference model state
   logic [3:0]  m_led;
   logic [7:0]  m_to_core;     // Host -> bus mailbox
   logic        m_full;
   logic [7:0]  m_from_core;   // Bus -> host mailbox
   logic        m_valid;
   logic [7:0]  m_hadr;        // Host address register
   logic        m_en;
   logic [soc_bus_pkg::FM_TUNE_W-1:0] m_tune;

   integer      seed;
   int          errors;
   int          checks;
   int          sva_fails;
   int          cycles;
   int unsigned sel;
   logic [31:0] d;
   logic [31:0] rd;
   logic [7:0]  hb;

   tb_clkgen u_clk (
      .CLK_I (CLK_I),
      .rst_n (rst_n)
   );

   periph_top UUT (
      .CLK_I       (CLK_I),
      .rst_n       (rst_n),
      .stb         (stb),
      .we          (we),
      .adr         (adr),
      .dat_w       (dat_w),
      .dat_r       (dat_r),
      .ack         (ack),
      .epp_astb_n  (epp_astb_n),
      .epp_dstb_n  (epp_dstb_n),
      .epp_write_n (epp_write_n),
      .epp_db_in   (epp_db_in),
      .epp_db_out  (epp_db_out),
      .epp_db_oe   (epp_db_oe),
      .epp_wait    (epp_wait),
      .led         (led),
      .antenna     (antenna)
   );

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // One bus access, called and left on a falling edge
   task automatic bus_op(input logic w, input logic [7:0] a, input logic [31:0] wd,
                         output logic [31:0] r);
      int n;
      stb   = 1'b1;
      we    = w;
      adr   = a;
      dat_w = wd;
      n     = 0;
      do begin
         @(negedge CLK_I);
         n++;
      end while (!ack && n < 4);
      assert (ack && n == 1) else begin
         errors++;
         $display("Bus access to address %h was not acknowledged after one cycle", a);
      end
      r   = dat_r;
      stb = 1'b0;   // Dropped within the ack cycle
      @(negedge CLK_I);
      assert (!ack) else begin
         errors++;
         $display("Bus access to address %h got a second ack", a);
      end
   endtask

   // One host strobe cycle, address or data
   task automatic host_op(input logic is_adr, input logic w, input logic [7:0] wd,
                          output logic [7:0] r);
      int n;
      epp_write_n = ~w;
      epp_db_in   = wd;
      if (is_adr) begin
         epp_astb_n = 1'b0;
      end else begin
         epp_dstb_n = 1'b0;
      end
      n = 0;
      do begin
         @(negedge CLK_I);
         n++;
      end while (!epp_wait && n < 10);
      assert (epp_wait && epp_db_oe == ~w) else begin
         errors++;
         $display("Host strobe got no wait response or a wrong data bus enable");
      end
      r          = epp_db_out;
      epp_astb_n = 1'b1;
      epp_dstb_n = 1'b1;
      n          = 0;
      do begin
         @(negedge CLK_I);
         n++;
      end while (epp_wait && n < 10);
      assert (!epp_wait && !epp_db_oe) else begin
         errors++;
         $display("Host wait did not fall after the strobe was released");
      end
   endtask

   function automatic logic [31:0] status_model();
      logic [31:0] st;
      st = '0;
      st[epp_pkg::ST_TO_CORE_FULL]    = m_full;
      st[epp_pkg::ST_FROM_CORE_VALID] = m_valid;
      return st;
   endfunction

   task automatic core_send_byte(input logic [31:0] wd);
      bus_op(1'b1, A_EPP, wd, rd);
      m_from_core = wd[7:0];
      m_valid     = 1'b1;
   endtask

   task automatic core_take_byte();
      bus_op(1'b0, A_EPP, 32'h0, rd);
      check_val("dat_r", rd, 32'(m_to_core));
      m_full = 1'b0;
   endtask

   task automatic core_read_status();
      bus_op(1'b0, A_STAT, 32'h0, rd);
      check_val("dat_r", rd, status_model());
   endtask

   task automatic host_set_addr(input logic [7:0] a);
      host_op(1'b1, 1'b1, a, hb);
      m_hadr = a;
   endtask

   task automatic host_write_byte(input logic [7:0] b);
      host_op(1'b0, 1'b1, b, hb);
      if (m_hadr == epp_pkg::EPP_REG_DATA) begin
         m_to_core = b;   // Overwrites an unread byte
         m_full    = 1'b1;
      end
   endtask

   task automatic host_read_byte();
      logic [7:0] exp;
      exp = 8'h00;   // Unmapped host register
      if (m_hadr == epp_pkg::EPP_REG_DATA) begin
         exp = m_from_core;
      end else if (m_hadr == epp_pkg::EPP_REG_STATUS) begin
         exp = 8'(status_model());
      end
      host_op(1'b0, 1'b0, 8'h00, hb);
      check_val("epp_db_out", 32'(hb), 32'(exp));
      if (m_hadr == epp_pkg::EPP_REG_DATA) begin
         m_valid = 1'b0;
      end
   endtask

   // Write tuning word, then follow the accumulator cycle by cycle
   task automatic fm_track(input logic [31:0] wd);
      logic [soc_bus_pkg::FM_PHASE_W-1:0] ph;
      logic [soc_bus_pkg::FM_PHASE_W-1:0] step;
      logic                               exp_ant;
      bus_op(1'b1, A_FM, wd, rd);
      m_en   = wd[soc_bus_pkg::FM_TUNE_W];
      m_tune = wd[soc_bus_pkg::FM_TUNE_W-1:0];
      step   = '0;
      step[soc_bus_pkg::FM_TUNE_W-1:0] = m_tune;
      ph     = '0;   // Cleared by the write
      repeat (FM_CYC) begin
         exp_ant = m_en & ph[soc_bus_pkg::FM_PHASE_W-1];   // One register behind
         if (m_en) begin
            ph = ph + step;
         end
         check_val("antenna", 32'(antenna), 32'(exp_ant));
         @(negedge CLK_I);
      end
      bus_op(1'b0, A_FM, 32'h0, rd);
      check_val("dat_r", rd, 32'({m_en, m_tune}));
   endtask

   // Run limit
   always @(posedge CLK_I) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("Timeout, run exceeded %0d cycles", LIMIT);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial begin
      seed        = 32'hed92_9c2f;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      stb         = 1'b0;
      we          = 1'b0;
      adr         = 8'h00;
      dat_w       = 32'h0;
      epp_astb_n  = 1'b1;
      epp_dstb_n  = 1'b1;
      epp_write_n = 1'b1;
      epp_db_in   = 8'h00;
      m_led       = 4'h0;
      m_to_core   = 8'h00;
      m_full      = 1'b0;
      m_from_core = 8'h00;
      m_valid     = 1'b0;
      m_hadr      = 8'h00;
      m_en        = 1'b0;
      m_tune      = '0;
      @(posedge rst_n);
      @(negedge CLK_I);

      // State after reset
      check_val("led", 32'(led), 32'h0);
      check_val("antenna", 32'(antenna), 32'h0);
      check_val("epp_wait", 32'(epp_wait), 32'h0);
      core_read_status();

      // Bus byte to the host, valid seen before the read and gone after
      core_send_byte($random(seed));
      host_set_addr(epp_pkg::EPP_REG_STATUS);
      host_read_byte();
      host_set_addr(epp_pkg::EPP_REG_DATA);
      host_read_byte();
      host_set_addr(epp_pkg::EPP_REG_STATUS);
      host_read_byte();

      // Two host bytes before one bus read, second byte wins
      host_set_addr(epp_pkg::EPP_REG_DATA);
      host_write_byte(8'($random(seed)));
      host_write_byte(8'($random(seed)));
      core_read_status();
      core_take_byte();
      core_read_status();

      for (int i = 0; i < N_FM; i++) begin
         d = $random(seed);
         if (i == 0) begin
            d[soc_bus_pkg::FM_TUNE_W] = 1'b1;   // At least one enabled run
         end
         fm_track(d);
      end

      for (int i = 0; i < N_BUS; i++) begin
         sel = $unsigned($random(seed)) % 8;
         d   = $random(seed);
         case (sel)
            0: begin
               bus_op(1'b1, A_LED, d, rd);
               m_led = d[3:0];
               check_val("led", 32'(led), 32'(m_led));
            end
            1: begin
               bus_op(1'b0, A_LED, 32'h0, rd);
               check_val("dat_r", rd, 32'(m_led));
            end
            2: begin
               bus_op(d[31], d[7:0] & 8'h8f, d, rd);   // No select bit
               check_val("dat_r", rd, 32'h0);
            end
            3: core_send_byte(d);
            4: core_take_byte();
            5: core_read_status();
            6: begin
               bus_op(1'b1, A_FM, d, rd);
               m_en   = d[soc_bus_pkg::FM_TUNE_W];
               m_tune = d[soc_bus_pkg::FM_TUNE_W-1:0];
            end
            default: begin
               bus_op(1'b0, A_FM, 32'h0, rd);
               check_val("dat_r", rd, 32'({m_en, m_tune}));
            end
         endcase
      end

      for (int i = 0; i < N_HOST; i++) begin
         sel = $unsigned($random(seed)) % 4;
         d   = $random(seed);
         case (sel)
            0: host_set_addr((d[3:0] == 4'h0) ? d[15:8] : {7'h0, d[8]});   // Mostly mapped
            1: host_write_byte(d[7:0]);
            2: host_read_byte();
            default: begin
               if (d[9]) begin
                  core_send_byte(d);
               end else begin
                  core_take_byte();
               end
            end
         endcase
      end

      sva_fails = UUT.u_ic.u_sva.fails + UUT.u_epp.u_sva.fails;
      $display("Value checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: sim/tb_clkgen.sv
// Testbench clock and reset source
// 10 ns clock, active-low reset held for 8 cycles
`timescale 1ns/100ps

module tb_clkgen (
   output logic CLK_I,
   output logic rst_n
);
   initial begin
      CLK_I = 1'b0;
      forever #5 CLK_I = ~CLK_I;
   end

   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge CLK_I);
      @(negedge CLK_I);   // Release away from the active edge
      rst_n = 1'b1;
   end

endmodule

// File: verilog/epp_pkg.sv
// Host parallel port register map
// Host register addresses, status bit positions
// and depth of the strobe synchronizer
package epp_pkg;

   // Host register addresses, loaded by an address strobe cycle
   localparam logic [7:0] EPP_REG_DATA   = 8'd0;   // Mailbox byte
   localparam logic [7:0] EPP_REG_STATUS = 8'd1;   // Mailbox flags

   // Status byte bits, same layout on host and bus side
   localparam int ST_TO_CORE_FULL    = 0;   // Host byte waiting for the bus
   localparam int ST_FROM_CORE_VALID = 1;   // Bus byte waiting for the host

   // Flops on each host strobe before use
   localparam int EPP_SYNC_STAGES = 2;

endpackage

// File: verilog/epp_port.sv
// Host parallel port slave
// Strobe synchronizers and host address register
// Wait handshake towards the host, split data bus in/out/enable
// To-core and from-core byte mailboxes with full/valid flags
// Bus slave side with one-cycle ack
`timescale 1ns/100ps

module epp_port (
   input  logic                           CLK_I,
   input  logic                           rst_n,
   input  logic                           stb,
   input  logic                           we,
   input  logic                           reg_sel,
   input  logic [soc_bus_pkg::BUS_DW-1:0] dat_w,
   input  logic                           epp_astb_n,
   input  logic                           epp_dstb_n,
   input  logic                           epp_write_n,
   input  logic [7:0]                     epp_db_in,
   output logic                           ack,
   output logic [soc_bus_pkg::BUS_DW-1:0] rdata,
   output logic [7:0]                     epp_db_out,
   output logic                           epp_db_oe,
   output logic                           epp_wait
);
   logic [epp_pkg::EPP_SYNC_STAGES-1:0] astb_sync;
   logic [epp_pkg::EPP_SYNC_STAGES-1:0] dstb_sync;
   logic       astb_s;              // Synchronized strobes, active low
   logic       dstb_s;
   logic       host_go;             // Action cycle of a host access
   logic       host_data;           // Data strobe cycle
   logic       host_wr;
   logic [7:0] host_adr_q;
   logic [7:0] to_core_q;           // Mailbox host -> bus
   logic       to_core_full_q;
   logic [7:0] from_core_q;         // Mailbox bus -> host
   logic       from_core_valid_q;
   logic [7:0] status;
   logic       bus_go;              // First stb cycle of a bus access
   logic       ack_q;
   logic [7:0] rd_byte_q;
   logic       full_set;
   logic       full_clr;
   logic       valid_set;
   logic       valid_clr;

   assign astb_s = astb_sync[epp_pkg::EPP_SYNC_STAGES-1];
   assign dstb_s = dstb_sync[epp_pkg::EPP_SYNC_STAGES-1];

   // One access per strobe, wait blocks repeats until release
   assign host_go   = ~epp_wait & ~(astb_s & dstb_s);
   assign host_data = ~dstb_s;
   assign host_wr   = ~epp_write_n;   // Held stable by the host during the strobe

   assign bus_go = stb & ~ack_q;

   // Flag updates from both sides
   assign full_set  = host_go & host_data & host_wr & (host_adr_q == epp_pkg::EPP_REG_DATA);
   assign valid_clr = host_go & host_data & ~host_wr & (host_adr_q == epp_pkg::EPP_REG_DATA);
   assign full_clr  = bus_go & ~we & ~reg_sel;
   assign valid_set = bus_go & we & ~reg_sel;

   always_comb begin
      status = '0;
      status[epp_pkg::ST_TO_CORE_FULL]    = to_core_full_q;
      status[epp_pkg::ST_FROM_CORE_VALID] = from_core_valid_q;
   end

   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         astb_sync <= '1;   // Strobes idle high
         dstb_sync <= '1;
      end else begin
         astb_sync <= {astb_sync[epp_pkg::EPP_SYNC_STAGES-2:0], epp_astb_n};
         dstb_sync <= {dstb_sync[epp_pkg::EPP_SYNC_STAGES-2:0], epp_dstb_n};
      end
   end

   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         epp_wait          <= 1'b0;
         epp_db_oe         <= 1'b0;
         host_adr_q        <= '0;
         to_core_full_q    <= 1'b0;
         from_core_valid_q <= 1'b0;
         ack_q             <= 1'b0;
      end else begin
         if (host_go) begin
            epp_wait  <= 1'b1;
            epp_db_oe <= ~host_wr;   // Drive bus only on host reads
            if (~host_data & host_wr) begin
               host_adr_q <= epp_db_in;
            end
         end else if (epp_wait & astb_s & dstb_s) begin
            epp_wait  <= 1'b0;       // Strobe release seen
            epp_db_oe <= 1'b0;
         end
         // A set in the same cycle wins, it carries the newer byte
         to_core_full_q    <= full_set | (to_core_full_q & ~full_clr);
         from_core_valid_q <= valid_set | (from_core_valid_q & ~valid_clr);
         ack_q             <= bus_go;
      end
   end

   // Mailbox bytes and read data
   always_ff @(posedge CLK_I) begin
      if (full_set) begin
         to_core_q <= epp_db_in;     // Overwrites an unread byte
      end
      if (valid_set) begin
         from_core_q <= dat_w[7:0];
      end
      if (host_go & ~host_wr) begin
         if (~host_data) begin
            epp_db_out <= host_adr_q;
         end else if (host_adr_q == epp_pkg::EPP_REG_DATA) begin
            epp_db_out <= from_core_q;
         end else if (host_adr_q == epp_pkg::EPP_REG_STATUS) begin
            epp_db_out <= status;
         end else begin
            epp_db_out <= '0;
         end
      end
      if (bus_go) begin
         rd_byte_q <= reg_sel ? status : to_core_q;
      end
   end

   assign ack   = ack_q;
   assign rdata = ack_q ? {{(soc_bus_pkg::BUS_DW-8){1'b0}}, rd_byte_q} : '0;

endmodule

// File: verilog/fm_nco.sv
// FM carrier generator
// Bus-programmed tuning word and enable
// Phase accumulator, top bit drives the antenna
`timescale 1ns/100ps

module fm_nco (
   input  logic                           CLK_I,
   input  logic                           rst_n,
   input  logic                           stb,
   input  logic                           we,
   input  logic [soc_bus_pkg::BUS_DW-1:0] dat_w,
   output logic                           ack,
   output logic [soc_bus_pkg::BUS_DW-1:0] rdata,
   output logic                           antenna
);
   logic                               ack_q;
   logic                               wr_go;     // First stb cycle of a write
   logic                               en_q;
   logic [soc_bus_pkg::FM_TUNE_W-1:0]  tune_q;
   logic [soc_bus_pkg::FM_PHASE_W-1:0] phase_q;

   assign wr_go = stb & we & ~ack_q;

   // Write clears phase at the edge that raises ack,
   // first add at the edge closing the ack cycle
   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         ack_q   <= 1'b0;
         en_q    <= 1'b0;
         tune_q  <= '0;
         phase_q <= '0;
         antenna <= 1'b0;
      end else begin
         ack_q   <= stb & ~ack_q;
         antenna <= en_q & phase_q[soc_bus_pkg::FM_PHASE_W-1];   // Zero while disabled
         if (wr_go) begin
            tune_q  <= dat_w[soc_bus_pkg::FM_TUNE_W-1:0];
            en_q    <= dat_w[soc_bus_pkg::FM_TUNE_W];       // Enable just above tuning word
            phase_q <= '0;
         end else if (en_q) begin
            phase_q <= phase_q +
                       {{(soc_bus_pkg::FM_PHASE_W-soc_bus_pkg::FM_TUNE_W){1'b0}}, tune_q};
         end
      end
   end

   assign ack   = ack_q;
   // Read back enable and tuning word
   assign rdata = ack_q ?
                  {{(soc_bus_pkg::BUS_DW-soc_bus_pkg::FM_TUNE_W-1){1'b0}}, en_q, tune_q} : '0;

endmodule

// File: verilog/periph_interconnect.sv
// Peripheral bus interconnect
// One-hot address decode into per-slave strobes
// Ack and read-data merge over all slaves
// LED register and default slave for unmapped addresses
`timescale 1ns/100ps

module periph_interconnect (
   input  logic                           CLK_I,
   input  logic                           rst_n,
   input  logic                           stb,
   input  logic                           we,
   input  logic [soc_bus_pkg::BUS_AW-1:0] adr,
   input  logic [soc_bus_pkg::BUS_DW-1:0] dat_w,
   input  logic                           epp_ack,
   input  logic [soc_bus_pkg::BUS_DW-1:0] epp_rdata,
   input  logic                           fm_ack,
   input  logic [soc_bus_pkg::BUS_DW-1:0] fm_rdata,
   output logic                           ack,
   output logic [soc_bus_pkg::BUS_DW-1:0] dat_r,
   output logic                           epp_stb,
   output logic                           fm_stb,
   output logic                           reg_sel,
   output logic [soc_bus_pkg::LED_W-1:0]  led
);
   logic                           led_hit;     // LED register addressed
   logic                           none_hit;    // No select bit set
   logic                           loc_ack_q;   // Ack for LED and unmapped
   logic [soc_bus_pkg::BUS_DW-1:0] loc_rdata;

   assign led_hit  = adr[soc_bus_pkg::SEL_LED_BIT];
   assign none_hit = ~(led_hit | adr[soc_bus_pkg::SEL_EPP_BIT] | adr[soc_bus_pkg::SEL_FM_BIT]);
   assign epp_stb  = stb & adr[soc_bus_pkg::SEL_EPP_BIT];
   assign fm_stb   = stb & adr[soc_bus_pkg::SEL_FM_BIT];
   assign reg_sel  = adr[soc_bus_pkg::REG_SEL_BIT];   // Shared by all slaves

   // Local slave, same one-cycle ack rule as the others
   always_ff @(posedge CLK_I or negedge rst_n) begin
      if (!rst_n) begin
         loc_ack_q <= 1'b0;
         led       <= '0;
      end else begin
         loc_ack_q <= stb & (led_hit | none_hit) & ~loc_ack_q;   // Ignore stb in ack cycle
         if (stb & led_hit & we & ~loc_ack_q) begin
            led <= dat_w[soc_bus_pkg::LED_W-1:0];
         end
      end
   end

   // Unmapped reads return zero
   assign loc_rdata = (loc_ack_q & led_hit & ~we) ?
                      {{(soc_bus_pkg::BUS_DW-soc_bus_pkg::LED_W){1'b0}}, led} : '0;

   // Slaves drive zero outside their ack cycle, so plain OR merge
   assign ack   = loc_ack_q | epp_ack | fm_ack;
   assign dat_r = loc_rdata | epp_rdata | fm_rdata;

endmodule

// File: verilog/periph_top.sv
// Peripheral subsystem top
// Bus interconnect with LED register, host parallel port
// and FM transmitter, bus master outside
`timescale 1ns/100ps

module periph_top (
   input  logic                           CLK_I,
   input  logic                           rst_n,
   input  logic                           stb,
   input  logic                           we,
   input  logic [soc_bus_pkg::BUS_AW-1:0] adr,
   input  logic [soc_bus_pkg::BUS_DW-1:0] dat_w,
   output logic [soc_bus_pkg::BUS_DW-1:0] dat_r,
   output logic                           ack,
   input  logic                           epp_astb_n,
   input  logic                           epp_dstb_n,
   input  logic                           epp_write_n,
   input  logic [7:0]                     epp_db_in,
   output logic [7:0]                     epp_db_out,
   output logic                           epp_db_oe,
   output logic                           epp_wait,
   output logic [soc_bus_pkg::LED_W-1:0]  led,
   output logic                           antenna
);
   logic                           epp_stb;
   logic                           epp_ack;
   logic [soc_bus_pkg::BUS_DW-1:0] epp_rdata;
   logic                           fm_stb;
   logic                           fm_ack;
   logic [soc_bus_pkg::BUS_DW-1:0] fm_rdata;
   logic                           reg_sel;   // Register bit for all slaves

   periph_interconnect u_ic (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .epp_ack   (epp_ack),
      .epp_rdata (epp_rdata),
      .fm_ack    (fm_ack),
      .fm_rdata  (fm_rdata),
      .ack       (ack),
      .dat_r     (dat_r),
      .epp_stb   (epp_stb),
      .fm_stb    (fm_stb),
      .reg_sel   (reg_sel),
      .led       (led)
   );

   epp_port u_epp (
      .CLK_I       (CLK_I),
      .rst_n       (rst_n),
      .stb         (epp_stb),
      .we          (we),
      .reg_sel     (reg_sel),
      .dat_w       (dat_w),
      .epp_astb_n  (epp_astb_n),
      .epp_dstb_n  (epp_dstb_n),
      .epp_write_n (epp_write_n),
      .epp_db_in   (epp_db_in),
      .ack         (epp_ack),
      .rdata       (epp_rdata),
      .epp_db_out  (epp_db_out),
      .epp_db_oe   (epp_db_oe),
      .epp_wait    (epp_wait)
   );

   fm_nco u_fm (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .stb     (fm_stb),
      .we      (we),
      .dat_w   (dat_w),
      .ack     (fm_ack),
      .rdata   (fm_rdata),
      .antenna (antenna)
   );

endmodule

// File: verilog/soc_bus_pkg.sv
// Bus and address map of the peripheral subsystem
// Data and address widths of the single-master bus
// One-hot peripheral select bits and register select bit
// LED count and FM transmitter widths
package soc_bus_pkg;

   // Bus widths
   localparam int BUS_DW = 32;       // Data word
   localparam int BUS_AW = 8;        // Byte address

   // One-hot select bits in the address, one per peripheral
   localparam int SEL_LED_BIT = 4;   // LED register
   localparam int SEL_EPP_BIT = 5;   // Host parallel port
   localparam int SEL_FM_BIT  = 6;   // FM transmitter

   // Register inside a peripheral
   localparam int REG_SEL_BIT = 2;   // 0 data, 1 status

   // LED output register
   localparam int LED_W = 4;

   // FM carrier generator
   localparam int FM_TUNE_W  = 15;   // Tuning word, enable sits just above it
   localparam int FM_PHASE_W = 20;   // Phase accumulator

endpackage

// File: vlog.f
verilog/soc_bus_pkg.sv
verilog/epp_pkg.sv
verilog/periph_interconnect.sv
verilog/epp_port.sv
verilog/fm_nco.sv
verilog/periph_top.sv
sim/tb_clkgen.sv
sim/periph_sva.sv
sim/periph_tb.sv
